// File: Bender.yml
package:
  name: pov_display

sources:
  - rotor_pkg.sv
  - display_pkg.sv
  - ir_index_decoder.sv
  - angle_tracker.sv
  - led_column_driver.sv
  - pov_display_top.sv
  - target: test
    files:
      - pov_display_chk.sv
      - pov_display_tb.sv

// File: angle_tracker.sv
`timescale 1ns/100ps
`default_nettype none

// measures the rotor period between index pulses and steps a discrete angle through it
module angle_tracker (
    input  logic                  clk_in,
    input  logic                  arst_n,
    input  logic                  index_pulse,  // one pulse per revolution from the decoder
    output rotor_pkg::angle_t     angle,        // current angle, 0 right after an index
    output logic                  angle_strobe, // high in each cycle angle takes a new value
    output rotor_pkg::rev_count_t period,       // cycles between the last two indexes
    output logic                  period_valid, // angle is trustworthy
    output logic                  stalled       // no index for STALL_LIMIT cycles
);

    // idle and stall both wait for a first index, measure waits for the second one
    typedef enum logic [1:0] {
        tracker_idle,
        tracker_measure,
        tracker_run,
        tracker_stall
    } tracker_state_t;

    tracker_state_t        state_q;
    tracker_state_t        state_d;
    rotor_pkg::rev_count_t rev_cnt;    // cycles since the last index, minus one
    rotor_pkg::rev_count_t new_period; // period seen if an index arrives this cycle
    rotor_pkg::rev_count_t step_raw;   // new period divided by the steps per revolution
    rotor_pkg::rev_count_t new_step;   // step_raw with the floor of 1 applied
    rotor_pkg::rev_count_t step_len;   // cycles per angle step, fixed until the next index
    rotor_pkg::rev_count_t step_cnt;   // position inside the current angle step
    logic                  counting;   // a revolution is being timed
    logic                  stall_hit;  // running count reached the stall limit
    logic                  take_index; // index that yields a usable period

    assign counting   = (state_q == tracker_measure) || (state_q == tracker_run);
    assign take_index = index_pulse && counting;
    assign stall_hit  = counting && (rev_cnt == rotor_pkg::STALL_LIMIT);

    assign new_period = rev_cnt + rotor_pkg::rev_count_t'(1); // counter starts at 0 after index
    assign step_raw   = new_period >> rotor_pkg::ANGLE_BITS;
    assign new_step   = (step_raw == '0) ? rotor_pkg::rev_count_t'(1) : step_raw;

    // outputs are plain decodes of the registered state
    assign period_valid = (state_q == tracker_run);
    assign stalled      = (state_q == tracker_stall);

    // an index always wins over a stall detected in the same cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            tracker_idle: begin
                if (index_pulse) state_d = tracker_measure; // first edge since reset
            end
            tracker_measure: begin
                if (index_pulse) begin
                    state_d = tracker_run; // a full revolution has now been timed
                end else if (stall_hit) begin
                    state_d = tracker_stall;
                end
            end
            tracker_run: begin
                if (stall_hit && !index_pulse) state_d = tracker_stall;
            end
            tracker_stall: begin
                if (index_pulse) state_d = tracker_measure; // fresh measurement needed
            end
            default: state_d = tracker_idle;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= tracker_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // the revolution counter only runs while timing, so it cannot wrap while idle or stalled
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rev_cnt <= '0;
        end else if (index_pulse || !counting) begin
            rev_cnt <= '0;
        end else begin
            rev_cnt <= rev_cnt + rotor_pkg::rev_count_t'(1);
        end
    end

    // period and step length latch together, a speed change shows up only at an index
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            period   <= '0;
            step_len <= rotor_pkg::rev_count_t'(1);
        end else if (take_index) begin
            period   <= new_period;
            step_len <= new_step;
        end
    end

    // angle stepping, the index restarts at 0 with a strobe so the bar shows column 0 at once
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            angle        <= '0;
            step_cnt     <= '0;
            angle_strobe <= 1'b0;
        end else begin
            angle_strobe <= 1'b0;
            if (take_index) begin
                angle        <= '0;
                step_cnt     <= '0;
                angle_strobe <= 1'b1;
            end else if ((state_q == tracker_run) && !stall_hit) begin
                if (step_cnt == step_len - rotor_pkg::rev_count_t'(1)) begin
                    step_cnt     <= '0;
                    angle        <= angle + rotor_pkg::angle_t'(1); // wraps at 1024
                    angle_strobe <= 1'b1;
                end else begin
                    step_cnt <= step_cnt + rotor_pkg::rev_count_t'(1);
                end
            end
            // in every other state angle holds its last value
        end
    end

endmodule

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

// frame buffer and LED bar definitions used by the column driver and the top level
package display_pkg;

    // the frame holds 2**COLUMN_BITS columns around one revolution
    localparam int unsigned COLUMN_BITS = 6;

    // depth of the frame buffer memory
    localparam int unsigned COLUMN_COUNT = 2 ** COLUMN_BITS;

    // number of LEDs on the bar, one bit each in a column word
    localparam int unsigned LED_COUNT = 16;

    // column index into the frame buffer, taken from the top angle bits
    typedef logic [COLUMN_BITS-1:0] column_t;

    // one LED column pattern, bit 0 drives the first LED on the bar
    typedef logic [LED_COUNT-1:0] led_t;

endpackage

`default_nettype wire

// File: ir_index_decoder.sv
`timescale 1ns/100ps
`default_nettype none

// turns the noisy asynchronous IR sensor level into one clean pulse per revolution
module ir_index_decoder (
    input  logic clk_in,
    input  logic arst_n,
    input  logic ir_raw,      // raw sensor level, no timing relation to clk_in
    output logic index_pulse  // one cycle high on each accepted rising edge
);

    logic [rotor_pkg::SYNC_STAGES-1:0] sync_q;   // synchronizer chain, bit 0 samples the pin
    logic                              sync_level; // last stage of the chain
    logic                              stable_level; // debounced sensor level
    rotor_pkg::debounce_count_t        deb_cnt;    // cycles the new level has held so far

    assign sync_level = sync_q[rotor_pkg::SYNC_STAGES-1];

    // plain shift chain to settle metastability before anything else looks at the level
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[rotor_pkg::SYNC_STAGES-2:0], ir_raw};
        end
    end

    // the debouncer only moves stable_level after DEBOUNCE_CYCLES matching samples in a row
    // any sample that agrees with the current stable level throws the count away, so
    // a short high glitch or a short low dropout never reaches the tracker
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            stable_level <= 1'b0;
            deb_cnt      <= '0;
            index_pulse  <= 1'b0;
        end else begin
            index_pulse <= 1'b0; // pulse lasts a single cycle
            if (sync_level == stable_level) begin
                deb_cnt <= '0; // disagreement gone, start over
            end else if (deb_cnt == rotor_pkg::DEBOUNCE_LAST) begin
                stable_level <= sync_level; // change has held long enough
                deb_cnt      <= '0;
                index_pulse  <= sync_level; // only the rising edge marks the index
            end else begin
                deb_cnt <= deb_cnt + rotor_pkg::debounce_count_t'(1);
            end
        end
    end

    // first sampled high of ir_raw lands in sync_q[0], reaches sync_level one edge later,
    // and the fourth matching sample after that raises index_pulse on the sixth edge

endmodule

`default_nettype wire

// File: led_column_driver.sv
`timescale 1ns/100ps
`default_nettype none

// frame buffer plus the register that drives the LED bar one column per angle step
module led_column_driver (
    input  logic                 clk_in,
    input  logic                 arst_n,
    input  logic                 wr_en,        // host write strobe, one cycle per word
    input  display_pkg::column_t wr_col,       // column being written
    input  display_pkg::led_t    wr_data,      // new pattern for that column
    input  rotor_pkg::angle_t    angle,        // current rotor angle
    input  logic                 angle_strobe, // angle just moved to a new step
    input  logic                 period_valid, // low means the angle cannot be trusted
    output display_pkg::led_t    led,          // pattern on the bar
    output logic                 led_strobe    // one cycle high when led takes a new column
);

    // one word per column, the host is the only writer
    display_pkg::led_t    frame_mem [display_pkg::COLUMN_COUNT];
    display_pkg::column_t rd_col; // column under the bar at the current angle

    // 1024 angles share 64 columns, so each column spans 16 consecutive angles
    assign rd_col = angle[rotor_pkg::ANGLE_BITS-1 -: display_pkg::COLUMN_BITS];

    // no reset on the frame contents, the host fills it before the rotor runs
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            frame_mem[wr_col] <= wr_data;
        end
    end

    // the read below samples frame_mem before this edge's write lands,
    // so a same-cycle write to the shown column appears on its next visit
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            led        <= '0;
            led_strobe <= 1'b0;
        end else begin
            led_strobe <= angle_strobe && period_valid;
            if (!period_valid) begin
                led <= '0; // blank the bar quietly, no strobe for this
            end else if (angle_strobe) begin
                led <= frame_mem[rd_col];
            end
        end
    end

endmodule

`default_nettype wire

// File: pov_display.f
rotor_pkg.sv
display_pkg.sv
ir_index_decoder.sv
angle_tracker.sv
led_column_driver.sv
pov_display_top.sv
pov_display_chk.sv
pov_display_tb.sv

// File: pov_display_chk.sv
`timescale 1ns/100ps
`default_nettype none

// port level rules of the POV display that are bound into the top level
module pov_display_chk (
    input logic              clk_in,
    input logic              arst_n,
    input logic              angle_strobe, // internal strobe from the tracker
    input logic              led_strobe,
    input rotor_pkg::angle_t angle,
    input display_pkg::led_t led,
    input logic              period_valid,
    input logic              stalled
);

    int assert_fails = 0; // summed into the testbench error count

    // each angle step reaches the bar exactly one cycle later
    led_follows_angle: assert property (@(posedge clk_in) disable iff (!arst_n)
        led_strobe == $past(angle_strobe))
        else begin
            assert_fails++;
            $error("led_strobe is not a one cycle delayed angle_strobe");
        end

    // a stalled rotor has no trusted period and its angle takes no further steps
    stall_is_quiet: assert property (@(posedge clk_in) disable iff (!arst_n)
        !(stalled && (period_valid || angle_strobe)))
        else begin
            assert_fails++;
            $error("period_valid or angle_strobe is high while stalled");
        end

    angle_moves_with_strobe: assert property (@(posedge clk_in) disable iff (!arst_n)
        !$stable(angle) |-> angle_strobe)
        else begin
            assert_fails++;
            $error("angle changed without angle_strobe");
        end

    // the bar blanks one cycle after period_valid drops and stays dark while it is low
    dark_without_period: assert property (@(posedge clk_in) disable iff (!arst_n)
        !period_valid |=> (led == '0))
        else begin
            assert_fails++;
            $error("led is lit while period_valid is low");
        end

endmodule

bind pov_display_top pov_display_chk pov_display_chk_inst (
    .clk_in       (clk_in),
    .arst_n       (arst_n),
    .angle_strobe (angle_strobe),
    .led_strobe   (led_strobe),
    .angle        (angle),
    .led          (led),
    .period_valid (period_valid),
    .stalled      (stalled)
);

`default_nettype wire

// File: pov_display_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pov_display_tb;

    // ten revolutions at 8192, the speed change, one stall and some slack for reset and waits
    localparam int planned_cycles = 10 * 8192 + 2 * 4096 + 2 * 3000 + (1 << 18) + 256;
    localparam int watchdog_ns    = planned_cycles * 4 * 12 / 10; // 4 ns clock with 20 percent margin
    localparam int col_shift      = rotor_pkg::ANGLE_BITS - display_pkg::COLUMN_BITS;

    logic                  clk_in;
    logic                  arst_n;
    logic                  ir_raw;
    logic                  wr_en;
    display_pkg::column_t  wr_col;
    display_pkg::led_t     wr_data;
    display_pkg::led_t     led;
    logic                  led_strobe;
    rotor_pkg::angle_t     angle;
    rotor_pkg::rev_count_t period;
    logic                  period_valid;
    logic                  stalled;

    display_pkg::led_t     frame_model [display_pkg::COLUMN_COUNT]; // host view of the buffer
    display_pkg::column_t  write_cols [$];  // pending host writes sent one per cycle
    display_pkg::led_t     write_words [$];
    logic [15:0]           lfsr_state;
    rotor_pkg::angle_t     prev_angle;      // angle one cycle back that the driver read
    bit                    led_check_on;
    bit                    prior_index;     // an index was seen since reset or stall
    int                    last_rev_len;    // length of the revolution just driven
    int                    error_count;
    int                    check_count;
    int                    test_count;
    int                    failed_tests;
    int                    strobe_count;

    always #2 clk_in = ~clk_in; // 4 ns period

    pov_display_top pov_display_top_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .ir_raw       (ir_raw),
        .wr_en        (wr_en),
        .wr_col       (wr_col),
        .wr_data      (wr_data),
        .led          (led),
        .led_strobe   (led_strobe),
        .angle        (angle),
        .period       (period),
        .period_valid (period_valid),
        .stalled      (stalled)
    );

    // right shifting taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] galois_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = galois_next(lfsr_state); // one step per bit taken
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic compare_angle(input string name, input rotor_pkg::angle_t expected,
                                 input rotor_pkg::angle_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_period(input string name, input rotor_pkg::rev_count_t expected,
                                  input rotor_pkg::rev_count_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_led(input string name, input display_pkg::led_t expected,
                               input display_pkg::led_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %-16s passed", name);
        end else begin
            failed_tests++;
            $display("test %-16s failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    // every strobe must show the model word for the column under the angle the driver read
    always @(negedge clk_in) begin
        if (led_strobe) begin
            strobe_count++;
            if (led_check_on) begin
                compare_led("led", frame_model[display_pkg::column_t'(prev_angle >> col_shift)],
                            led);
            end
        end
        prev_angle = angle;
    end

    // one revolution of rev_len cycles with the sensor high for the first 16
    // and the index seen at offset 7
    task automatic spin(input int rev_len, input bit glitchy);
        bit run_now;
        int step;
        int glitch_left;
        run_now     = prior_index; // the tracker runs only if this index closes a measurement
        step        = last_rev_len >> rotor_pkg::ANGLE_BITS;
        glitch_left = 0;
        if (step < 1) begin
            step = 1; // floor of the step length
        end
        for (int i = 0; i < rev_len; i++) begin
            @(negedge clk_in);
            if (i == 7) begin
                compare_flag("period_valid", run_now, period_valid);
                compare_flag("stalled", 1'b0, stalled); // any index leaves the stall state
                if (run_now) begin
                    compare_period("period", rotor_pkg::rev_count_t'(last_rev_len), period);
                end
            end
            if (run_now && i >= 7) begin
                compare_angle("angle", rotor_pkg::angle_t'((i - 7) / step), angle); // wraps by cast
            end
            // short high glitches of 1 to 3 cycles well away from the real edge
            if (glitchy && i >= 1024 && i % 512 == 0 && i < rev_len - 256) begin
                glitch_left = 1 + int'(random_bits(2)) % 3;
            end
            ir_raw = (i < 16) || (glitch_left > 0);
            if (glitch_left > 0) begin
                glitch_left--;
            end
            wr_en = (write_cols.size() > 0);
            if (wr_en) begin
                wr_col                = write_cols.pop_front();
                wr_data               = write_words.pop_front();
                frame_model[wr_col]   = wr_data; // written columns are away from the bar here
            end
        end
        prior_index  = 1'b1;
        last_rev_len = rev_len;
    endtask

    task automatic reset_state_test();
        int errs;
        errs = error_count;
        compare_angle("angle", '0, angle);
        compare_period("period", '0, period);
        compare_led("led", '0, led);
        compare_flag("led_strobe", 1'b0, led_strobe);
        compare_flag("period_valid", 1'b0, period_valid);
        compare_flag("stalled", 1'b0, stalled);
        spin(8192, 1'b0); // a lone index only starts a measurement
        compare_flag("period_valid", 1'b0, period_valid);
        if (strobe_count != 0) begin
            report_error("led_strobe pulsed after a single index");
        end
        finish_test("reset state", errs);
    endtask

    task automatic debounce_test();
        int errs;
        errs = error_count;
        spin(8192, 1'b1); // angle checks inside catch any glitch taken as an index
        spin(8192, 1'b1);
        compare_period("period", rotor_pkg::rev_count_t'(8192), period);
        finish_test("debounce", errs);
    endtask

    task automatic angle_step_test();
        int errs;
        errs = error_count;
        spin(8192, 1'b0); // step length 8 so angle is the offset divided by 8
        spin(8192, 1'b0);
        finish_test("angle stepping", errs);
    endtask

    task automatic frame_buffer_test();
        int errs;
        int strobes_before;
        errs = error_count;
        for (int c = 0; c < display_pkg::COLUMN_COUNT; c++) begin
            write_cols.push_back(display_pkg::column_t'(c));
            write_words.push_back(display_pkg::led_t'(random_bits(display_pkg::LED_COUNT)));
        end
        spin(8192, 1'b0); // words go in during the first 64 cycles
        led_check_on   = 1'b1;
        strobes_before = strobe_count;
        spin(8192, 1'b0);
        // a steady revolution shows one column for each of its angles
        if (strobe_count - strobes_before != (1 << rotor_pkg::ANGLE_BITS)) begin
            report_error($sformatf("%0d LED columns in one revolution, %0d expected",
                                   strobe_count - strobes_before, 1 << rotor_pkg::ANGLE_BITS));
        end
        write_cols.push_back(display_pkg::column_t'(32)); // shown near offset 4100 long after
        write_words.push_back(display_pkg::led_t'(random_bits(display_pkg::LED_COUNT)));
        spin(8192, 1'b0);
        led_check_on = 1'b0;
        finish_test("frame buffer", errs);
    endtask

    task automatic speed_change_test();
        int errs;
        errs = error_count;
        spin(4096, 1'b0); // still stepping by 8 from the last 8192 interval
        spin(4096, 1'b0); // step 4
        spin(3000, 1'b0); // step 4 holds until the next index
        spin(3000, 1'b0); // step 2
        compare_period("period", rotor_pkg::rev_count_t'(3000), period);
        finish_test("speed change", errs);
    endtask

    task automatic stall_recovery_test();
        int errs;
        int waited;
        int expect_wait;
        int strobes_before;
        rotor_pkg::angle_t frozen;
        errs        = error_count;
        waited      = 0;
        expect_wait = int'(rotor_pkg::STALL_LIMIT) + 9 - last_rev_len; // index was at offset 7
        while (!stalled && waited < expect_wait + 64) begin
            @(negedge clk_in);
            waited++;
        end
        if (!stalled) begin
            report_error("stalled did not rise with the sensor held low");
        end else if (waited != expect_wait) begin
            report_error($sformatf("stalled rose after %0d cycles, %0d expected", waited,
                                   expect_wait));
        end
        compare_flag("period_valid", 1'b0, period_valid);
        @(negedge clk_in);
        compare_led("led", '0, led); // blanked one cycle after period_valid fell
        frozen         = angle;
        strobes_before = strobe_count;
        repeat (64) @(negedge clk_in);
        compare_angle("angle", frozen, angle);
        compare_flag("stalled", 1'b1, stalled);
        if (strobe_count != strobes_before) begin
            report_error("led_strobe pulsed while stalled");
        end
        prior_index = 1'b0; // the next index starts a fresh measurement
        spin(8192, 1'b0);
        compare_flag("period_valid", 1'b0, period_valid);
        strobes_before = strobe_count;
        led_check_on   = 1'b1;
        spin(8192, 1'b0);
        led_check_on   = 1'b0;
        if (strobe_count == strobes_before) begin
            report_error("no LED columns shown after recovery");
        end
        finish_test("stall recovery", errs);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not end within %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk_in       = 1'b0;
        arst_n       = 1'b0;
        ir_raw       = 1'b0;
        wr_en        = 1'b0;
        wr_col       = '0;
        wr_data      = '0;
        lfsr_state   = 16'd3;
        prev_angle   = '0;
        led_check_on = 1'b0;
        prior_index  = 1'b0;
        last_rev_len = 0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        strobe_count = 0;
        repeat (4) @(negedge clk_in);
        arst_n = 1'b1;
        reset_state_test();
        debounce_test();
        angle_step_test();
        frame_buffer_test();
        speed_change_test();
        stall_recovery_test();
        error_count += pov_display_top_inst.pov_display_chk_inst.assert_fails;
        $display("tests %0d, failed %0d, checks %0d, errors %0d", test_count, failed_tests,
                 check_count, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pov_display_top.sv
`timescale 1ns/100ps
`default_nettype none

// POV LED bar, IR index decode feeds angle tracking which feeds the column output
module pov_display_top (
    input  logic                  clk_in,
    input  logic                  arst_n,
    input  logic                  ir_raw,       // IR index sensor, asynchronous
    input  logic                  wr_en,        // frame buffer write strobe
    input  display_pkg::column_t  wr_col,
    input  display_pkg::led_t     wr_data,
    output display_pkg::led_t     led,          // LED bar pattern
    output logic                  led_strobe,   // new column on the bar
    output rotor_pkg::angle_t     angle,
    output rotor_pkg::rev_count_t period,
    output logic                  period_valid,
    output logic                  stalled
);

    logic index_pulse;  // decoder to tracker, once per revolution
    logic angle_strobe; // tracker to driver, once per angle step

    ir_index_decoder ir_index_decoder_inst (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .ir_raw      (ir_raw),
        .index_pulse (index_pulse)
    );

    // stalled goes straight out, the driver blanks on period_valid alone
    angle_tracker angle_tracker_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .index_pulse  (index_pulse),
        .angle        (angle),
        .angle_strobe (angle_strobe),
        .period       (period),
        .period_valid (period_valid),
        .stalled      (stalled)
    );

    led_column_driver led_column_driver_inst (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .wr_col       (wr_col),
        .wr_data      (wr_data),
        .angle        (angle),
        .angle_strobe (angle_strobe),
        .period_valid (period_valid),
        .led          (led),
        .led_strobe   (led_strobe)
    );

endmodule

`default_nettype wire

// File: rotor_pkg.sv
`default_nettype none

// rotor timing and angle definitions shared by the decoder, the tracker and the top level
package rotor_pkg;

    // a revolution is split into 2**ANGLE_BITS discrete angle steps
    localparam int unsigned ANGLE_BITS = 10;

    // width of the per-revolution cycle counter and of the measured period
    localparam int unsigned REV_COUNT_BITS = 24;

    // flip-flops between the raw sensor pin and the debouncer
    localparam int unsigned SYNC_STAGES = 2;

    // cycles a new synchronized level must hold before the debouncer accepts it
    localparam int unsigned DEBOUNCE_CYCLES = 4;
    localparam int unsigned DEBOUNCE_BITS   = $clog2(DEBOUNCE_CYCLES); // counter 0..DEBOUNCE_CYCLES-1

    // cycle count within one revolution, used for both the running count and the period
    typedef logic [REV_COUNT_BITS-1:0] rev_count_t;

    // discrete rotor angle, wraps from 1023 back to 0
    typedef logic [ANGLE_BITS-1:0] angle_t;

    // debounce stability counter
    typedef logic [DEBOUNCE_BITS-1:0] debounce_count_t;

    // with no index for this many cycles the rotor is taken as stopped
    localparam rev_count_t STALL_LIMIT = rev_count_t'(2 ** 18);

    // last count value before a new level is accepted
    localparam debounce_count_t DEBOUNCE_LAST = debounce_count_t'(DEBOUNCE_CYCLES - 1);

endpackage

`default_nettype wire
